// ==== hdl/apb_iob_macros.svh ====
`ifndef APB_IOB_MACROS_SVH
`define APB_IOB_MACROS_SVH

// Bus widths shared by the APB ports, the bridges and the memory
`define APB_IOB_ADDR_W 12
`define APB_IOB_DATA_W 32

// One write enable per data byte
`define APB_IOB_STRB_W (`APB_IOB_DATA_W / 8)

// Memory geometry
`define APB_IOB_MEM_DEPTH 256

// Word index slice of the byte address
`define APB_IOB_IDX_LSB 2
`define APB_IOB_IDX_W 8

`endif

// ==== hdl/apb_iob_pkg.sv ====
`include "apb_iob_macros.svh"

package apb_iob_pkg;

   typedef logic [`APB_IOB_ADDR_W-1:0] addr_t;  // Byte address
   typedef logic [`APB_IOB_DATA_W-1:0] data_t;  // One memory word
   typedef logic [`APB_IOB_STRB_W-1:0] strb_t;  // Byte write enables
   typedef logic [`APB_IOB_IDX_W-1:0]  idx_t;   // Memory word index

   // APB master to slave
   typedef struct packed {
      logic  sel;
      logic  enable;
      logic  write;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } apb_req_t;

   // APB slave to master
   typedef struct packed {
      logic  ready;
      data_t rdata;
   } apb_rsp_t;

   // IOb master to slave, zero strobe is a read
   typedef struct packed {
      logic  valid;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } iob_req_t;

   // IOb slave to master
   typedef struct packed {
      logic  ready;
      logic  rvalid;
      data_t rdata;
   } iob_rsp_t;

   typedef enum logic [1:0] {
      WAIT_ENABLE    = 2'd0,
      WAIT_READY     = 2'd1,
      RVALID         = 2'd2,
      WAIT_APB_READY = 2'd3
   } bridge_state_e;

endpackage

// ==== hdl/apb2iob.sv ====
`timescale 1ns/1ps

module apb2iob (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_iob_pkg::apb_req_t apb_req_i,
   input  apb_iob_pkg::iob_rsp_t iob_rsp_i,
   output apb_iob_pkg::apb_rsp_t apb_rsp_o,
   output apb_iob_pkg::iob_req_t iob_req_o
);

   apb_iob_pkg::bridge_state_e state_q;
   apb_iob_pkg::bridge_state_e state_d;

   logic               apb_ready_q;
   logic               apb_ready_d;
   apb_iob_pkg::data_t apb_rdata_q;
   apb_iob_pkg::strb_t iob_wstrb;
   logic               iob_read;

   // Reads go out with an all-zero strobe
   assign iob_wstrb = apb_req_i.write ? apb_req_i.wstrb : '0;
   assign iob_read  = (iob_wstrb == '0);

   // IOb request, address and data straight from the APB side
   assign iob_req_o.valid = (state_q == apb_iob_pkg::WAIT_READY);
   assign iob_req_o.addr  = apb_req_i.addr;
   assign iob_req_o.wdata = apb_req_i.wdata;
   assign iob_req_o.wstrb = iob_wstrb;

   assign apb_rsp_o.ready = apb_ready_q;
   assign apb_rsp_o.rdata = apb_rdata_q;

   // One IOb transaction per APB access phase
   always_comb begin
      state_d     = state_q;
      apb_ready_d = 1'b0;

      unique case (state_q)
         apb_iob_pkg::WAIT_ENABLE: begin
            if (apb_req_i.sel && apb_req_i.enable) begin
               state_d = apb_iob_pkg::WAIT_READY;
            end
         end
         apb_iob_pkg::WAIT_READY: begin
            // Hold valid until the slave takes it
            if (iob_rsp_i.ready) begin
               if (iob_read) begin
                  state_d = apb_iob_pkg::RVALID;
               end else begin
                  state_d     = apb_iob_pkg::WAIT_APB_READY;
                  apb_ready_d = 1'b1;  // Write done
               end
            end
         end
         apb_iob_pkg::RVALID: begin
            if (iob_rsp_i.rvalid) begin
               state_d     = apb_iob_pkg::WAIT_APB_READY;
               apb_ready_d = 1'b1;
            end
         end
         default: begin
            // APB ready is high in this state
            state_d = apb_iob_pkg::WAIT_ENABLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= apb_iob_pkg::WAIT_ENABLE;
         apb_ready_q <= 1'b0;
      end else begin
         state_q     <= state_d;
         apb_ready_q <= apb_ready_d;
      end
   end

   // Read data held for the APB master
   always_ff @(posedge clk_i) begin
      if (iob_rsp_i.rvalid) begin
         apb_rdata_q <= iob_rsp_i.rdata;
      end
   end

endmodule

// ==== hdl/iob_arbiter.sv ====
`timescale 1ns/1ps

module iob_arbiter (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_iob_pkg::iob_req_t m0_req_i,
   input  apb_iob_pkg::iob_req_t m1_req_i,
   input  apb_iob_pkg::iob_rsp_t mem_rsp_i,
   output apb_iob_pkg::iob_rsp_t m0_rsp_o,
   output apb_iob_pkg::iob_rsp_t m1_rsp_o,
   output apb_iob_pkg::iob_req_t mem_req_o
);

   logic last_q;        // High when master 1 was served last
   logic lock_q;        // Read outstanding
   logic lock_owner_q;  // Master waiting for read data
   logic lock_busy;
   logic gnt0;
   logic gnt1;
   logic accept;
   logic accept_rd;

   // Lock drops in the cycle the read data comes back
   assign lock_busy = lock_q & ~mem_rsp_i.rvalid;

   always_comb begin
      gnt0 = 1'b0;
      gnt1 = 1'b0;
      if (lock_busy) begin
         gnt0 = ~lock_owner_q;
         gnt1 = lock_owner_q;
      end else if (m0_req_i.valid && m1_req_i.valid) begin
         // Both want the bus, the one not served last wins
         gnt0 = last_q;
         gnt1 = ~last_q;
      end else begin
         gnt0 = m0_req_i.valid;
         gnt1 = m1_req_i.valid;
      end
   end

   // Forward the granted request
   always_comb begin
      mem_req_o       = gnt1 ? m1_req_i : m0_req_i;
      mem_req_o.valid = ~lock_busy & ((gnt0 & m0_req_i.valid) | (gnt1 & m1_req_i.valid));
   end

   assign accept    = mem_req_o.valid & mem_rsp_i.ready;
   assign accept_rd = accept & (mem_req_o.wstrb == '0);

   // Ready to the granted master, read data to the lock owner
   always_comb begin
      m0_rsp_o.ready  = gnt0 & ~lock_busy & mem_rsp_i.ready;
      m0_rsp_o.rvalid = mem_rsp_i.rvalid & lock_q & ~lock_owner_q;
      m0_rsp_o.rdata  = mem_rsp_i.rdata;

      m1_rsp_o.ready  = gnt1 & ~lock_busy & mem_rsp_i.ready;
      m1_rsp_o.rvalid = mem_rsp_i.rvalid & lock_q & lock_owner_q;
      m1_rsp_o.rdata  = mem_rsp_i.rdata;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         last_q       <= 1'b0;
         lock_q       <= 1'b0;
         lock_owner_q <= 1'b0;
      end else begin
         if (lock_q && mem_rsp_i.rvalid) begin
            lock_q <= 1'b0;
         end
         if (accept) begin
            last_q <= gnt1;
            // A new read may start as the previous data returns
            if (accept_rd) begin
               lock_q       <= 1'b1;
               lock_owner_q <= gnt1;
            end
         end
      end
   end

endmodule

// ==== hdl/iob_sram.sv ====
`timescale 1ns/1ps

`include "apb_iob_macros.svh"

module iob_sram (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_iob_pkg::iob_req_t iob_req_i,
   output apb_iob_pkg::iob_rsp_t iob_rsp_o
);

   apb_iob_pkg::data_t mem_q [`APB_IOB_MEM_DEPTH];
   apb_iob_pkg::idx_t  idx;
   apb_iob_pkg::data_t rdata_q;
   logic               rvalid_q;
   logic               wr_en;
   logic               rd_en;

   // Upper address bits are ignored, so addresses alias
   assign idx   = iob_req_i.addr[`APB_IOB_IDX_LSB +: `APB_IOB_IDX_W];
   assign wr_en = iob_req_i.valid & (iob_req_i.wstrb != '0);
   assign rd_en = iob_req_i.valid & (iob_req_i.wstrb == '0);

   // Never stalls
   assign iob_rsp_o.ready  = 1'b1;
   assign iob_rsp_o.rvalid = rvalid_q;
   assign iob_rsp_o.rdata  = rdata_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `APB_IOB_MEM_DEPTH; i++) begin
            mem_q[i] <= '0;
         end
      end else if (wr_en) begin
         for (int b = 0; b < `APB_IOB_STRB_W; b++) begin
            if (iob_req_i.wstrb[b]) begin
               mem_q[idx][8*b +: 8] <= iob_req_i.wdata[8*b +: 8];  // Byte lane b
            end
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;  // One cycle pulse per read
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_q <= mem_q[idx];
      end
   end

endmodule

// ==== hdl/apb_mem_subsystem.sv ====
`timescale 1ns/1ps

module apb_mem_subsystem (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_iob_pkg::apb_req_t apb0_req_i,
   input  apb_iob_pkg::apb_req_t apb1_req_i,
   output apb_iob_pkg::apb_rsp_t apb0_rsp_o,
   output apb_iob_pkg::apb_rsp_t apb1_rsp_o
);

   apb_iob_pkg::iob_req_t bridge0_req;
   apb_iob_pkg::iob_req_t bridge1_req;
   apb_iob_pkg::iob_rsp_t bridge0_rsp;
   apb_iob_pkg::iob_rsp_t bridge1_rsp;
   apb_iob_pkg::iob_req_t mem_req;
   apb_iob_pkg::iob_rsp_t mem_rsp;

   // APB port 0
   apb2iob u_bridge0 (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .apb_req_i(apb0_req_i),
      .iob_rsp_i(bridge0_rsp),
      .apb_rsp_o(apb0_rsp_o),
      .iob_req_o(bridge0_req)
   );

   // APB port 1
   apb2iob u_bridge1 (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .apb_req_i(apb1_req_i),
      .iob_rsp_i(bridge1_rsp),
      .apb_rsp_o(apb1_rsp_o),
      .iob_req_o(bridge1_req)
   );

   iob_arbiter u_arbiter (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .m0_req_i (bridge0_req),
      .m1_req_i (bridge1_req),
      .mem_rsp_i(mem_rsp),
      .m0_rsp_o (bridge0_rsp),
      .m1_rsp_o (bridge1_rsp),
      .mem_req_o(mem_req)
   );

   // Shared word memory
   iob_sram u_sram (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .iob_req_i(mem_req),
      .iob_rsp_o(mem_rsp)
   );

endmodule

// ==== verif/apb_mem_checker.sv ====
`timescale 1ns/1ps

module apb_mem_checker (
   input logic                  clk_i,
   input logic                  rst_n_i,
   input apb_iob_pkg::apb_req_t apb0_req_i,
   input apb_iob_pkg::apb_req_t apb1_req_i,
   input apb_iob_pkg::apb_rsp_t apb0_rsp_i,
   input apb_iob_pkg::apb_rsp_t apb1_rsp_i,
   input apb_iob_pkg::iob_req_t m0_req_i,
   input apb_iob_pkg::iob_req_t m1_req_i,
   input apb_iob_pkg::iob_rsp_t m0_rsp_i,
   input apb_iob_pkg::iob_rsp_t m1_rsp_i,
   input apb_iob_pkg::iob_req_t mem_req_i,
   input apb_iob_pkg::iob_rsp_t mem_rsp_i
);

   int unsigned assert_fails = 0;

   // IOb ready reaches only the granted master
   one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(m0_rsp_i.ready && m1_rsp_i.ready))
      else begin
         assert_fails++;
         $error("Both IOb masters granted in the same cycle");
      end

   // Read data goes back only to the master whose read was taken
   rvalid_after_read0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m0_rsp_i.rvalid |-> $past(m0_req_i.valid && m0_rsp_i.ready && m0_req_i.wstrb == '0))
      else begin
         assert_fails++;
         $error("Master 0 rvalid without its accepted read one cycle earlier");
      end

   rvalid_after_read1: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m1_rsp_i.rvalid |-> $past(m1_req_i.valid && m1_rsp_i.ready && m1_req_i.wstrb == '0))
      else begin
         assert_fails++;
         $error("Master 1 rvalid without its accepted read one cycle earlier");
      end

   apb0_ready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      apb0_rsp_i.ready |-> (apb0_req_i.sel && apb0_req_i.enable))
      else begin
         assert_fails++;
         $error("APB port 0 ready outside an access phase");
      end

   apb1_ready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      apb1_rsp_i.ready |-> (apb1_req_i.sel && apb1_req_i.enable))
      else begin
         assert_fails++;
         $error("APB port 1 ready outside an access phase");
      end

   // Everything quiet while in reset
   quiet_in_reset: assert property (@(posedge clk_i)
      !rst_n_i |-> !(apb0_rsp_i.ready || apb1_rsp_i.ready || mem_req_i.valid ||
                     m0_rsp_i.ready || m1_rsp_i.ready || mem_rsp_i.rvalid))
      else begin
         assert_fails++;
         $error("Valid or ready high during reset");
      end

endmodule

bind apb_mem_subsystem apb_mem_checker u_checker (
   .clk_i     (clk_i),
   .rst_n_i   (rst_n_i),
   .apb0_req_i(apb0_req_i),
   .apb1_req_i(apb1_req_i),
   .apb0_rsp_i(apb0_rsp_o),
   .apb1_rsp_i(apb1_rsp_o),
   .m0_req_i  (bridge0_req),
   .m1_req_i  (bridge1_req),
   .m0_rsp_i  (bridge0_rsp),
   .m1_rsp_i  (bridge1_rsp),
   .mem_req_i (mem_req),
   .mem_rsp_i (mem_rsp)
);

// ==== verif/tb_apb_mem_subsystem.sv ====
`timescale 1ns/1ps

`include "apb_iob_macros.svh"

module tb_apb_mem_subsystem;

   localparam int CLK_HALF     = 5;
   localparam int RESET_CYCLES = 5;
   localparam int RESET_READS  = 16;   // Spread over both ports
   localparam int STRB_ROUNDS  = 16;   // One write and one read each
   localparam int RANDOM_OPS   = 150;  // Per port
   localparam int ALIAS_ROUNDS = 4;    // One write and three reads each
   localparam int NUM_ACCESSES = RESET_READS + 4 + 2 * STRB_ROUNDS + 2 * RANDOM_OPS + 4 +
                                 4 * ALIAS_ROUNDS;
   localparam int TIMEOUT_CYCLES = 20 * NUM_ACCESSES + RESET_CYCLES;

   logic                  clk;
   logic                  rst_n;
   apb_iob_pkg::apb_req_t apb0_req;
   apb_iob_pkg::apb_req_t apb1_req;
   apb_iob_pkg::apb_rsp_t apb0_rsp;
   apb_iob_pkg::apb_rsp_t apb1_rsp;

   apb_iob_pkg::data_t model_mem [`APB_IOB_MEM_DEPTH];  // Expected memory contents
   logic [31:0]        rng_state;
   int unsigned        cycle_count;

   apb_mem_subsystem u_apb_mem_subsystem (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .apb0_req_i(apb0_req),
      .apb1_req_i(apb1_req),
      .apb0_rsp_o(apb0_rsp),
      .apb1_rsp_o(apb1_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // Stuck handshake or a failed protocol assertion ends the run
   always @(posedge clk) begin
      cycle_count++;
      if (u_apb_mem_subsystem.u_checker.assert_fails != 0) begin
         $display("A protocol assertion in the bound checker failed");
         $display("Test failures found");
         $fatal(1, "Stopping at the first assertion failure");
      end else if (cycle_count > TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failures found");
         $fatal(1, "Simulation timed out");
      end
   end

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic apb_iob_pkg::idx_t word_index(input apb_iob_pkg::addr_t addr);
      return addr[`APB_IOB_IDX_LSB +: `APB_IOB_IDX_W];
   endfunction

   // Word index placed in the middle, junk in the offset and upper bits
   function automatic apb_iob_pkg::addr_t make_addr(input apb_iob_pkg::idx_t idx,
                                                    input logic [3:0] junk);
      apb_iob_pkg::addr_t addr;
      addr = '0;
      addr[`APB_IOB_IDX_LSB +: `APB_IOB_IDX_W] = idx;
      addr[`APB_IOB_IDX_LSB-1:0] = junk[1:0];
      addr[`APB_IOB_ADDR_W-1:`APB_IOB_IDX_LSB+`APB_IOB_IDX_W] = junk[3:2];
      return addr;
   endfunction

   function automatic apb_iob_pkg::data_t merge_bytes(input apb_iob_pkg::data_t old_word,
                                                      input apb_iob_pkg::data_t new_word,
                                                      input apb_iob_pkg::strb_t strb);
      apb_iob_pkg::data_t merged;
      merged = old_word;
      for (int b = 0; b < `APB_IOB_STRB_W; b++) begin
         if (strb[b]) begin
            merged[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return merged;
   endfunction

   function automatic apb_iob_pkg::apb_rsp_t port_rsp(input int port);
      return (port == 0) ? apb0_rsp : apb1_rsp;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
         $display("Test failures found");
         $fatal(1, "Stopping at the first mismatch");
      end
   endtask

   task automatic drive_port(input int port, input apb_iob_pkg::apb_req_t req);
      if (port == 0) begin
         apb0_req = req;
      end else begin
         apb1_req = req;
      end
   endtask

   // Setup, access until ready, then one idle cycle
   task automatic apb_access(input int port, input logic write, input apb_iob_pkg::addr_t addr,
                             input apb_iob_pkg::data_t wdata, input apb_iob_pkg::strb_t wstrb,
                             output apb_iob_pkg::data_t rdata, output int cycles);
      apb_iob_pkg::apb_req_t req;
      apb_iob_pkg::apb_rsp_t rsp;
      req       = '0;
      req.sel   = 1'b1;
      req.write = write;
      req.addr  = addr;
      req.wdata = wdata;
      req.wstrb = wstrb;
      @(posedge clk);
      #1 drive_port(port, req);
      @(posedge clk);
      req.enable = 1'b1;
      #1 drive_port(port, req);
      cycles = 0;
      do begin
         @(posedge clk);
         #1 cycles++;
         rsp = port_rsp(port);
      end while (!rsp.ready);
      rdata = rsp.rdata;
      @(posedge clk);  // Transfer completes at this edge
      #1 drive_port(port, '0);
   endtask

   task automatic write_word(input int port, input apb_iob_pkg::addr_t addr,
                             input apb_iob_pkg::data_t wdata, input apb_iob_pkg::strb_t strb,
                             output int cycles);
      apb_iob_pkg::data_t rdata_unused;
      apb_access(port, 1'b1, addr, wdata, strb, rdata_unused, cycles);
      model_mem[word_index(addr)] = merge_bytes(model_mem[word_index(addr)], wdata, strb);
   endtask

   task automatic read_check(input int port, input string name, input apb_iob_pkg::addr_t addr,
                             input apb_iob_pkg::strb_t strb, output int cycles);
      apb_iob_pkg::data_t expected;
      apb_iob_pkg::data_t actual;
      expected = model_mem[word_index(addr)];
      apb_access(port, 1'b0, addr, lcg_next(), strb, actual, cycles);
      check_value(name, expected, actual);
   endtask

   task automatic random_master(input int port);
      logic [31:0]        r;
      apb_iob_pkg::addr_t addr;
      apb_iob_pkg::strb_t strb;
      int                 cycles;
      for (int i = 0; i < RANDOM_OPS; i++) begin
         r    = lcg_next();
         addr = make_addr({port[0], r[30:24]}, r[23:20]);  // Port 1 owns the upper half
         strb = r[19:16];
         if (r[31]) begin
            if (strb == '0) begin
               strb = 4'b0001;
            end
            write_word(port, addr, lcg_next(), strb, cycles);
         end else begin
            read_check(port, $sformatf("random_read_p%0d", port), addr, strb, cycles);
         end
      end
   endtask

   initial begin
      logic [31:0]        r;
      apb_iob_pkg::addr_t addr;
      apb_iob_pkg::data_t wdata;
      apb_iob_pkg::strb_t strb;
      int                 cycles;

      rng_state   = 32'd80936;
      cycle_count = 0;
      rst_n       = 1'b0;
      apb0_req    = '0;
      apb1_req    = '0;
      for (int i = 0; i < `APB_IOB_MEM_DEPTH; i++) begin
         model_mem[i] = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;

      // Reset state
      check_value("reset_apb0_ready", 32'd0, apb0_rsp.ready);
      check_value("reset_apb1_ready", 32'd0, apb1_rsp.ready);
      for (int i = 0; i < RESET_READS; i++) begin
         r = lcg_next();
         read_check(i % 2, "reset_read_zero", r[31:20], '0, cycles);
      end

      // Uncontended latency on each port
      for (int p = 0; p < 2; p++) begin
         r     = lcg_next();
         wdata = lcg_next();
         write_word(p, r[31:20], wdata, 4'hf, cycles);
         check_value($sformatf("basic_write_latency_p%0d", p), 32'd2, cycles);
         read_check(p, $sformatf("basic_read_data_p%0d", p), r[31:20], '0, cycles);
         check_value($sformatf("basic_read_latency_p%0d", p), 32'd3, cycles);
      end

      // Byte merges on one word
      r    = lcg_next();
      addr = r[31:20];
      for (int i = 0; i < STRB_ROUNDS; i++) begin
         r    = lcg_next();
         strb = r[31:28];
         if (strb == '0) begin
            strb = 4'b1000;
         end
         write_word(0, addr, lcg_next(), strb, cycles);
         r = lcg_next();
         read_check(0, "strobe_merge", addr, r[31:28], cycles);  // Read strobe is ignored
      end

      // Both ports under arbitration
      fork
         random_master(0);
         random_master(1);
      join

      // Write on one port, read on the other
      for (int src = 0; src < 2; src++) begin
         r = lcg_next();
         write_word(src, r[31:20], lcg_next(), 4'hf, cycles);
         read_check(1 - src, "cross_port_read", r[31:20], '0, cycles);
      end

      for (int i = 0; i < ALIAS_ROUNDS; i++) begin
         r = lcg_next();
         write_word(i % 2, make_addr(r[31:24], 4'b0000), lcg_next(), 4'hf, cycles);
         for (int j = 1; j < 4; j++) begin
            read_check(j % 2, "alias_read", make_addr(r[31:24], {2'(j), r[2*j +: 2]}), '0,
                       cycles);
         end
      end

      if (u_apb_mem_subsystem.u_checker.assert_fails == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/apb_iob_pkg.sv
hdl/apb2iob.sv
hdl/iob_arbiter.sv
hdl/iob_sram.sv
hdl/apb_mem_subsystem.sv
verif/apb_mem_checker.sv
verif/tb_apb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: apb_mem_subsystem

sources:
  # Synthesizable design
  - include_dirs:
      - hdl
    files:
      - hdl/apb_iob_pkg.sv
      - hdl/apb2iob.sv
      - hdl/iob_arbiter.sv
      - hdl/iob_sram.sv
      - hdl/apb_mem_subsystem.sv

  # Verification sources
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/apb_mem_checker.sv
      - verif/tb_apb_mem_subsystem.sv
